//--- adc_rng.f
source/adc_rng_pkg.sv
source/adc_lsb_debias.sv
source/adc_health_mon.sv
source/adc_rng_fifo.sv
source/rng_word_ctrl.sv
source/adc_rng_top.sv
verif/adc_rng_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= adc_rng_tb
FILELIST  ?= adc_rng.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell cat $(FILELIST))
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "^sim passed$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- verif/adc_rng_tb.sv
`timescale 1ns/1ps

module adc_rng_tb
    import adc_rng_pkg::*;
();

    localparam int REP_LIMIT    = 16;
    localparam int RESET_CYCLES = 16;
    localparam int SEED         = 63;
    localparam int LATENCY      = 3;
    localparam int N_RANDOM     = 400;
    localparam int DRAIN_CYCLES = 20;
    localparam int NOT_SENT     = 32'h3fff_ffff;

    logic        clk;
    logic        rst;
    logic        sample_valid;
    adc_sample_t sample;
    rng_word_t   rng_word;
    logic        word_valid;
    logic        health_alarm;

    // stimulus, and idle cycles before each sample
    adc_sample_t stim[$];
    int          gaps[$];
    // cycle in which each sample is presented to the DUT
    int          samp_cyc[];
    rng_word_t   exp_words[$];
    // index of the sample that completes each expected word
    int          exp_last[$];
    int          alarm_at;
    logic        gen_prev;
    int          gen_run;
    int          cyc = 0;
    bit          stim_ready = 1'b0;
    int          limit;
    int          got = 0;
    int          word_errs = 0;
    int          bit_errs = 0;
    int          seq_errs = 0;

    adc_rng_top #(
        .REP_LIMIT (REP_LIMIT)
    ) dut0 (
        .clk          (clk),
        .rst          (rst),
        .sample_valid (sample_valid),
        .sample       (sample),
        .rng_word     (rng_word),
        .word_valid   (word_valid),
        .health_alarm (health_alarm)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    // expected words and the sample index that raises the alarm
    function automatic int ref_model(input adc_sample_t smp[$], output rng_word_t words[$],
                                     output int last_idx[$]);
        int        alarm_idx;
        int        run_len;
        int        nbits;
        logic      lsb;
        logic      prev_lsb;
        logic      first_lsb;
        logic      second;
        rng_word_t acc;
        alarm_idx = -1;
        run_len   = 0;
        nbits     = 0;
        prev_lsb  = 1'b0;
        first_lsb = 1'b0;
        second    = 1'b0;
        acc       = '0;
        for (int i = 0; i < smp.size(); i++) begin
            lsb = smp[i][0];
            // repetition count on raw lsbs
            if (run_len > 0 && lsb == prev_lsb) begin
                run_len++;
            end else begin
                run_len = 1;
            end
            prev_lsb = lsb;
            if (alarm_idx < 0 && run_len >= REP_LIMIT) begin
                alarm_idx = i;
            end
            // von neumann: 10 gives 1, 01 gives 0, equal pairs dropped
            if (!second) begin
                first_lsb = lsb;
            end else if (lsb != first_lsb) begin
                acc[nbits] = first_lsb;
                nbits++;
                if (nbits == RNG_WIDTH) begin
                    // once halted, words stay in the collector
                    if (alarm_idx < 0) begin
                        words.push_back(acc);
                        last_idx.push_back(i);
                    end
                    nbits = 0;
                    acc   = '0;
                end
            end
            second = !second;
        end
        return alarm_idx;
    endfunction

    task automatic add_sample(input logic lsb, input int idle);
        adc_sample_t s;
        s    = adc_sample_t'($urandom);
        s[0] = lsb;
        if (stim.size() > 0 && lsb == gen_prev) begin
            gen_run++;
        end else begin
            gen_run = 1;
        end
        gen_prev = lsb;
        stim.push_back(s);
        gaps.push_back(idle);
    endtask

    // corrected bit equals b
    task automatic add_pair(input logic b, input int idle);
        add_sample(b, idle);
        add_sample(!b, 0);
    endtask

    task automatic build_stimulus();
        logic [19:0] pattern;
        logic        lsb;
        logic        eq;
        // directed pairs, two words of known bits
        pattern = 20'hA5C3E;
        for (int i = 0; i < 20; i++) begin
            add_pair(pattern[i], 0);
        end
        // equal pairs interleaved, these give no bits
        pattern = 20'h3C96B;
        for (int i = 0; i < 20; i++) begin
            add_pair(pattern[i], 0);
            eq = 1'($urandom % 2);
            add_sample(eq, int'($urandom % 3));
            add_sample(eq, 0);
        end
        // random lsbs, mostly back to back, runs kept under the limit
        for (int i = 0; i < N_RANDOM; i++) begin
            lsb = 1'($urandom % 2);
            if (gen_run >= REP_LIMIT - 1 && lsb == gen_prev) begin
                lsb = !lsb;
            end
            add_sample(lsb, ($urandom % 4 == 0) ? int'($urandom % 3) : 0);
        end
        // stuck lsb long enough for the alarm, then more good pairs
        lsb = !gen_prev;
        for (int i = 0; i < REP_LIMIT; i++) begin
            add_sample(lsb, 0);
        end
        for (int i = 0; i < 3 * RNG_WIDTH; i++) begin
            add_pair(1'($urandom % 2), 0);
        end
    endtask

    task automatic check_word(input string name, input rng_word_t exp, input rng_word_t act);
        if (act !== exp) begin
            word_errs++;
            $display("ERROR %0d ns %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            bit_errs++;
            $display("ERROR %0d ns %s expected %b actual %b", $time, name, exp, act);
        end
    endtask

    // compare process, outputs sampled mid cycle
    initial begin
        int due;
        bit alarm_seen;
        alarm_seen = 1'b0;
        wait (stim_ready);
        // first cycle out of reset
        @(negedge clk);
        while (rst) begin
            @(negedge clk);
        end
        check_word("rng_word", '0, rng_word);
        check_bit("word_valid", 1'b0, word_valid);
        forever begin
            check_bit("health_alarm", (alarm_at >= 0) && (cyc > samp_cyc[alarm_at]),
                      health_alarm);
            if (word_valid && alarm_seen) begin
                seq_errs++;
                $display("word_valid at %0d ns after the health alarm rose", $time);
            end
            if (word_valid && got >= exp_words.size()) begin
                seq_errs++;
                $display("unexpected word_valid at %0d ns, no word is due", $time);
            end else if (word_valid) begin
                check_word("rng_word", exp_words[got], rng_word);
                due = samp_cyc[exp_last[got]] + LATENCY;
                if (cyc != due) begin
                    seq_errs++;
                    $display("word %0d came in cycle %0d, due in cycle %0d", got, cyc, due);
                end
                got++;
            end
            alarm_seen = alarm_seen || (health_alarm === 1'b1);
            @(negedge clk);
        end
    end

    initial begin
        wait (stim_ready);
        #(limit);
        $display("run timed out after %0d ns", limit);
        $display("sim failed");
        $finish;
    end

    initial begin
        int total;
        int missing;
        rst          <= 1'b1;
        sample_valid <= 1'b0;
        sample       <= '0;
        void'($urandom(SEED));
        gen_run  = 0;
        gen_prev = 1'b0;
        build_stimulus();
        alarm_at = ref_model(stim, exp_words, exp_last);
        samp_cyc = new[stim.size()];
        foreach (samp_cyc[i]) begin
            samp_cyc[i] = NOT_SENT;
        end
        // 4 ns per cycle, twice over, plus margin
        total = RESET_CYCLES + DRAIN_CYCLES;
        foreach (gaps[i]) begin
            total += 1 + gaps[i];
        end
        limit      = total * 4 * 2 + 200;
        stim_ready = 1'b1;

        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        for (int k = 0; k < stim.size(); k++) begin
            repeat (gaps[k]) begin
                @(posedge clk);
                sample_valid <= 1'b0;
            end
            @(posedge clk);
            sample_valid <= 1'b1;
            sample       <= stim[k];
            samp_cyc[k]   = cyc + 1;
        end
        @(posedge clk);
        sample_valid <= 1'b0;
        repeat (DRAIN_CYCLES) @(posedge clk);

        missing = exp_words.size() - got;
        if (missing != 0) begin
            $display("%0d expected words never arrived", missing);
        end
        if (alarm_at < 0) begin
            missing++;
            $display("stimulus never reached the repetition limit");
        end
        $display("errors: word %0d, flag %0d, sequence %0d, missing %0d",
                 word_errs, bit_errs, seq_errs, missing);
        if (word_errs + bit_errs + seq_errs + missing == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule : adc_rng_tb

//--- source/adc_rng_top.sv
`timescale 1ns/1ps

module adc_rng_top
    import adc_rng_pkg::*;
#(
    parameter int REP_LIMIT = 16
)(
    input  logic        clk,
    input  logic        rst,
    input  logic        sample_valid,
    input  adc_sample_t sample,
    output rng_word_t   rng_word,
    output logic        word_valid,
    output logic        health_alarm
);

    logic      bit_valid;
    logic      rand_bit;
    logic      full;
    logic      deque;
    rng_word_t vector;

    adc_lsb_debias debias0 (
        .clk          (clk),
        .rst          (rst),
        .sample_valid (sample_valid),
        .sample       (sample),
        .bit_valid    (bit_valid),
        .rand_bit     (rand_bit)
    );

    // watches raw lsbs, before the corrector
    adc_health_mon #(
        .REP_LIMIT (REP_LIMIT)
    ) health0 (
        .clk          (clk),
        .rst          (rst),
        .sample_valid (sample_valid),
        .sample       (sample),
        .health_alarm (health_alarm)
    );

    adc_rng_fifo fifo0 (
        .clk    (clk),
        .rst    (rst),
        .enque  (bit_valid),
        .deque  (deque),
        .data   (rand_bit),
        .vector (vector),
        .full   (full)
    );

    rng_word_ctrl ctrl0 (
        .clk          (clk),
        .rst          (rst),
        .full         (full),
        .vector       (vector),
        .health_alarm (health_alarm),
        .deque        (deque),
        .rng_word     (rng_word),
        .word_valid   (word_valid)
    );

endmodule : adc_rng_top

//--- source/rng_word_ctrl.sv
`timescale 1ns/1ps

module rng_word_ctrl
    import adc_rng_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      full,
    input  rng_word_t vector,
    input  logic      health_alarm,
    output logic      deque,
    output rng_word_t rng_word,
    output logic      word_valid
);

    ctrl_state_t state_q;
    ctrl_state_t state_d;

    // halted is terminal until reset
    always_comb begin
        state_d = state_q;
        unique case (state_q)
            run: begin
                if (health_alarm) begin
                    state_d = halted;
                end
            end
            halted: begin
                state_d = halted;
            end
            default: begin
                state_d = halted;
            end
        endcase
    end

    // drain on full, but not in the cycle the alarm is already up
    assign deque = (state_q == run) && full && !health_alarm;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q    <= run;
            rng_word   <= '0;
            word_valid <= 1'b0;
        end else begin
            state_q    <= state_d;
            word_valid <= deque;
            if (deque) begin
                rng_word <= vector;
            end
        end
    end

    // strobe one cycle after a drain, and the emptied collector ends the drain
    assert property (@(posedge clk) disable iff (rst)
        deque |=> word_valid && !deque);

endmodule : rng_word_ctrl

//--- source/adc_rng_fifo.sv
`timescale 1ns/1ps

module adc_rng_fifo
    import adc_rng_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      enque,
    input  logic      deque,
    input  logic      data,
    output rng_word_t vector,
    output logic      full
);

    // next write position
    bit_idx_t  head_q;
    bit_idx_t  head_d;
    rng_word_t bits_q;
    rng_word_t bits_d;
    logic      empty;

    // status straight from the registered head
    assign full  = (head_q == bit_idx_t'(RNG_WIDTH));
    assign empty = (head_q == '0);

    always_comb begin
        head_d = head_q;
        bits_d = bits_q;
        vector = '0;

        if (deque && !empty) begin
            // whole word leaves, head restarts
            vector = bits_q;
            if (enque) begin
                // bit arriving now opens the next word
                bits_d[0] = data;
                head_d    = bit_idx_t'(1);
            end else begin
                head_d = '0;
            end
        end else if (enque && !full) begin
            bits_d[head_q] = data;
            head_d         = head_q + 1'b1;
        end
        // enque while full is dropped
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            head_q <= '0;
        end else begin
            head_q <= head_d;
        end
    end

    always_ff @(posedge clk) begin
        bits_q <= bits_d;
    end

    // head stays inside the word
    assert property (@(posedge clk) disable iff (rst)
        head_q <= bit_idx_t'(RNG_WIDTH));

endmodule : adc_rng_fifo

//--- source/adc_health_mon.sv
`timescale 1ns/1ps

module adc_health_mon
    import adc_rng_pkg::*;
#(
    parameter int REP_LIMIT = 16
)(
    input  logic        clk,
    input  logic        rst,
    input  logic        sample_valid,
    input  adc_sample_t sample,
    output logic        health_alarm
);

    localparam int CNT_W = $clog2(REP_LIMIT + 1);

    // run length of equal lsbs, 0 means no sample seen yet
    logic [CNT_W-1:0] count_q;
    logic [CNT_W-1:0] count_d;
    logic             prev_lsb_q;

    always_comb begin
        count_d = count_q;
        if (sample_valid) begin
            if ((count_q != '0) && (sample[0] == prev_lsb_q)) begin
                // saturate at the limit
                if (count_q != CNT_W'(REP_LIMIT)) begin
                    count_d = count_q + 1'b1;
                end
            end else begin
                count_d = CNT_W'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            count_q      <= '0;
            health_alarm <= 1'b0;
        end else begin
            count_q <= count_d;
            // sticky until reset
            if (sample_valid && (count_d == CNT_W'(REP_LIMIT))) begin
                health_alarm <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (sample_valid) begin
            prev_lsb_q <= sample[0];
        end
    end

    // alarm only clears through reset
    assert property (@(posedge clk) $fell(health_alarm) |-> $past(rst));

endmodule : adc_health_mon

//--- source/adc_lsb_debias.sv
`timescale 1ns/1ps

module adc_lsb_debias
    import adc_rng_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        sample_valid,
    input  adc_sample_t sample,
    output logic        bit_valid,
    output logic        rand_bit
);

    // high while waiting for the second sample of a pair
    logic second_q;
    // lsb of the first sample of the pair
    logic first_lsb_q;
    logic lsb;

    assign lsb = sample[0];

    // pair phase and corrected bit strobe
    always_ff @(posedge clk) begin
        if (rst) begin
            second_q  <= 1'b0;
            bit_valid <= 1'b0;
        end else begin
            bit_valid <= 1'b0;
            if (sample_valid) begin
                second_q <= ~second_q;
                // 01 -> 0, 10 -> 1, equal pair dropped
                if (second_q && (lsb != first_lsb_q)) begin
                    bit_valid <= 1'b1;
                end
            end
        end
    end

    // held lsb and output bit
    always_ff @(posedge clk) begin
        if (sample_valid) begin
            if (!second_q) begin
                first_lsb_q <= lsb;
            end else begin
                rand_bit <= first_lsb_q;
            end
        end
    end

    // a pair needs two samples, so strobes are never back to back
    assert property (@(posedge clk) disable iff (rst)
        bit_valid |=> !bit_valid);

endmodule : adc_lsb_debias

//--- source/adc_rng_pkg.sv
package adc_rng_pkg;

    // adc sample width
    localparam int ADC_WIDTH = 12;

    // random bits per output word
    localparam int RNG_WIDTH = 10;

    typedef logic [ADC_WIDTH-1:0] adc_sample_t;

    typedef logic [RNG_WIDTH-1:0] rng_word_t;

    // write position in the collector, 0 .. RNG_WIDTH
    typedef logic [3:0] bit_idx_t;

    // output controller states
    typedef enum logic {
        run    = 1'b0,
        halted = 1'b1
    } ctrl_state_t;

endpackage : adc_rng_pkg
